//--- source/fpu_defines.svh
// number format widths for the FPU job unit, included by every RTL file that sizes a datapath
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// --------------------------------------------------
// memory side
// --------------------------------------------------

// one memory word
`define FPU_WORD_W 16
// words per memory operand
`define FPU_WORDS  3

// --------------------------------------------------
// packed number: fraction then exponent
// --------------------------------------------------

`define FPU_MANT_W 40
`define FPU_EXP_W  8
`define FPU_NUM_W  48

`endif

//--- source/fpu_pkg.sv
// shared opcode and sequencer state types, referenced by scoped name from the RTL
`default_nettype none

package fpu_pkg;

	// --------------------------------------------------
	// job opcodes carried with efp
	// --------------------------------------------------

	typedef enum logic [1:0] {
		// normalize the accumulator only
		OP_NRF = 2'd0,
		// accumulator plus memory operand
		OP_AD  = 2'd1,
		// accumulator minus memory operand
		OP_SD  = 2'd2
	} fp_op_e;

	// --------------------------------------------------
	// job sequencer states
	// --------------------------------------------------

	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0,
		// three word reads under the LP counter
		ST_FETCH = 3'd1,
		ST_ALIGN = 3'd2,
		ST_ADD   = 3'd3,
		ST_NORM  = 3'd4,
		// ekc_fp cycle
		ST_DONE  = 3'd5
	} fp_state_e;

endpackage

`default_nettype wire

//--- source/fpu_step_if.sv
// step commands from the job sequencer to the datapath blocks and their status back
`timescale 1ns/1ps
`default_nettype none

interface fpu_step_if;

	// commands
	logic       load_acc;
	logic       word_take;
	logic [1:0] word_idx;
	logic       align_go;
	logic       add_go;
	logic       sub;
	logic       norm_go;
	// normalizer takes the accumulator instead of the sum
	logic       norm_acc;

	// status, both are levels
	logic       align_done;
	logic       norm_done;

	modport ctrl (
		output load_acc, word_take, word_idx, align_go, add_go, sub, norm_go, norm_acc,
		input  align_done, norm_done
	);

	modport unit (
		input  load_acc, word_take, word_idx, align_go, add_go, sub, norm_go, norm_acc,
		output align_done, norm_done
	);

endinterface

`default_nettype wire

//--- source/fpu_control.sv
// job sequencer FSM with the LP word counter, memory read strobe and datapath step commands
`timescale 1ns/1ps
`default_nettype none
`include "fpu_defines.svh"

module fpu_control (
	input  wire                   got_fp,
	input  wire                   _0_f,
	input  wire                   efp,
	input  wire fpu_pkg::fp_op_e  op,
	output logic                  read_fp,
	output logic [1:0]            lp,
	input  wire                   mem_ok,
	output logic                  ekc_fp,
	output logic                  busy,
	fpu_step_if.ctrl              stp
);

	fpu_pkg::fp_state_e state;
	fpu_pkg::fp_op_e    op_q;
	logic               align_first;
	logic               norm_first;
	logic               start;
	logic               last_word;

	// job accepted only when idle
	assign start     = efp & (state == fpu_pkg::ST_IDLE);
	assign last_word = (lp == 2'(`FPU_WORDS - 1));

	// --------------------------------------------------
	// state register, LP counter, read strobe
	// --------------------------------------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			state       <= fpu_pkg::ST_IDLE;
			op_q        <= fpu_pkg::OP_NRF;
			lp          <= 2'd0;
			read_fp     <= 1'b0;
			align_first <= 1'b0;
			norm_first  <= 1'b0;
		end else begin
			read_fp     <= 1'b0;
			align_first <= 1'b0;
			norm_first  <= 1'b0;
			case (state)
				fpu_pkg::ST_IDLE: begin
					if (efp) begin
						op_q <= op;
						case (op)
							// norm_go goes out in this cycle
							fpu_pkg::OP_NRF: state <= fpu_pkg::ST_NORM;
							fpu_pkg::OP_AD, fpu_pkg::OP_SD: begin
								state   <= fpu_pkg::ST_FETCH;
								lp      <= 2'd0;
								read_fp <= 1'b1;
							end
							default: state <= fpu_pkg::ST_IDLE;
						endcase
					end
				end
				fpu_pkg::ST_FETCH: begin
					if (mem_ok) begin
						if (last_word) begin
							lp          <= 2'd0;
							state       <= fpu_pkg::ST_ALIGN;
							align_first <= 1'b1;
						end else begin
							// next read right after the answer
							lp      <= lp + 2'd1;
							read_fp <= 1'b1;
						end
					end
				end
				fpu_pkg::ST_ALIGN: begin
					// align_done is stale while align_go is still up
					if (stp.align_done && !align_first) begin
						state <= fpu_pkg::ST_ADD;
					end
				end
				fpu_pkg::ST_ADD: begin
					state      <= fpu_pkg::ST_NORM;
					norm_first <= 1'b1;
				end
				fpu_pkg::ST_NORM: begin
					if (stp.norm_done && !norm_first) begin
						state <= fpu_pkg::ST_DONE;
					end
				end
				fpu_pkg::ST_DONE: state <= fpu_pkg::ST_IDLE;
				default: state <= fpu_pkg::ST_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// status and step commands
	// --------------------------------------------------

	assign ekc_fp = (state == fpu_pkg::ST_DONE);
	assign busy   = (state != fpu_pkg::ST_IDLE);

	assign stp.load_acc  = start;
	assign stp.word_take = mem_ok & (state == fpu_pkg::ST_FETCH);
	assign stp.word_idx  = lp;
	assign stp.align_go  = align_first;
	assign stp.add_go    = (state == fpu_pkg::ST_ADD);
	assign stp.sub       = (op_q == fpu_pkg::OP_SD);
	// nrf loads acc_in straight off the strobe
	assign stp.norm_go   = norm_first | (start & (op == fpu_pkg::OP_NRF));
	assign stp.norm_acc  = (state == fpu_pkg::ST_IDLE);

endmodule

`default_nettype wire

//--- source/operand_loader.sv
// collects the three fetched memory words and presents them as one packed operand
`timescale 1ns/1ps
`default_nettype none
`include "fpu_defines.svh"

module operand_loader (
	input  wire                   got_fp,
	input  wire                   _0_f,
	input  wire [`FPU_WORD_W-1:0] mem_word,
	fpu_step_if.unit              stp,
	output logic [`FPU_NUM_W-1:0] operand
);

	// word 0 is the high end of the fraction
	logic [`FPU_WORD_W-1:0] word_q [`FPU_WORDS];

	// --------------------------------------------------
	// word registers, indexed by the LP counter
	// --------------------------------------------------

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			for (int i = 0; i < `FPU_WORDS; i++) begin
				word_q[i] <= '0;
			end
		end else if (stp.word_take) begin
			for (int i = 0; i < `FPU_WORDS; i++) begin
				if (stp.word_idx == 2'(i)) begin
					word_q[i] <= mem_word;
				end
			end
		end
	end

	// mantissa 39..8 from words 0 and 1, word 2 has mantissa 7..0 then the exponent
	assign operand = {word_q[0], word_q[1], word_q[2]};

endmodule

`default_nettype wire

//--- source/exponent_align.sv
// holds accumulator and operand and shifts the smaller-exponent mantissa right until exponents match
`timescale 1ns/1ps
`default_nettype none
`include "fpu_defines.svh"

module exponent_align (
	input  wire                    got_fp,
	input  wire                    _0_f,
	input  wire  [`FPU_NUM_W-1:0]  acc_in,
	input  wire  [`FPU_NUM_W-1:0]  operand,
	fpu_step_if.unit               stp,
	output logic [`FPU_MANT_W-1:0] mant_a,
	output logic [`FPU_MANT_W-1:0] mant_b,
	output logic [`FPU_EXP_W-1:0]  exp_out
);

	logic signed [`FPU_MANT_W-1:0] a_m;
	logic signed [`FPU_MANT_W-1:0] b_m;
	logic signed [`FPU_EXP_W-1:0]  a_e;
	logic signed [`FPU_EXP_W-1:0]  b_e;
	logic                          active;
	logic                          a_fill;
	logic                          b_fill;

	// mantissa is nothing but sign bits, further shifts change nothing
	assign a_fill = (a_m == {`FPU_MANT_W{a_m[`FPU_MANT_W-1]}});
	assign b_fill = (b_m == {`FPU_MANT_W{b_m[`FPU_MANT_W-1]}});

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			active <= 1'b0;
		end else if (stp.align_go) begin
			active <= 1'b1;
		end else if (stp.load_acc || (a_e == b_e)) begin
			active <= 1'b0;
		end
	end

	// --------------------------------------------------
	// operand registers and the shift step
	// --------------------------------------------------

	always_ff @(posedge got_fp) begin
		if (stp.load_acc) begin
			a_m <= acc_in[`FPU_NUM_W-1 -: `FPU_MANT_W];
			a_e <= acc_in[`FPU_EXP_W-1:0];
		end else if (active && (a_e < b_e)) begin
			if (a_fill) begin
				a_e <= b_e;
			end else begin
				a_m <= a_m >>> 1;
				a_e <= a_e + 1'b1;
			end
		end
		if (stp.align_go) begin
			b_m <= operand[`FPU_NUM_W-1 -: `FPU_MANT_W];
			b_e <= operand[`FPU_EXP_W-1:0];
		end else if (active && (b_e < a_e)) begin
			if (b_fill) begin
				b_e <= a_e;
			end else begin
				b_m <= b_m >>> 1;
				b_e <= b_e + 1'b1;
			end
		end
	end

	assign stp.align_done = (a_e == b_e);
	assign mant_a         = a_m;
	assign mant_b         = b_m;
	assign exp_out        = a_e;

endmodule

`default_nettype wire

//--- source/mantissa_adder.sv
// one-cycle add or subtract of the aligned mantissas with overflow correction into the exponent
`timescale 1ns/1ps
`default_nettype none
`include "fpu_defines.svh"

module mantissa_adder (
	input  wire                    got_fp,
	input  wire                    _0_f,
	input  wire  [`FPU_MANT_W-1:0] mant_a,
	input  wire  [`FPU_MANT_W-1:0] mant_b,
	input  wire  [`FPU_EXP_W-1:0]  exp_in,
	fpu_step_if.unit               stp,
	output logic [`FPU_MANT_W-1:0] sum,
	output logic [`FPU_EXP_W:0]    sum_exp
);

	logic [`FPU_MANT_W:0] a_x;
	logic [`FPU_MANT_W:0] b_x;
	logic [`FPU_MANT_W:0] wide;
	logic [`FPU_EXP_W:0]  exp_x;
	logic                 carry_out;

	// one guard bit on top of each operand
	assign a_x   = {mant_a[`FPU_MANT_W-1], mant_a};
	assign b_x   = {mant_b[`FPU_MANT_W-1], mant_b};
	assign wide  = stp.sub ? (a_x - b_x) : (a_x + b_x);
	assign exp_x = {exp_in[`FPU_EXP_W-1], exp_in};

	// guard and sign disagree, sign lost
	assign carry_out = wide[`FPU_MANT_W] ^ wide[`FPU_MANT_W-1];

	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			sum     <= '0;
			sum_exp <= '0;
		end else if (stp.add_go) begin
			if (carry_out) begin
				// halve the sum, guard bit becomes the sign
				sum     <= wide[`FPU_MANT_W:1];
				sum_exp <= exp_x + 1'b1;
			end else begin
				sum     <= wide[`FPU_MANT_W-1:0];
				sum_exp <= exp_x;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/normalizer.sv
// left-shift normalization of the sum or accumulator, with zero and exponent range flags
`timescale 1ns/1ps
`default_nettype none
`include "fpu_defines.svh"

module normalizer (
	input  wire                    got_fp,
	input  wire                    _0_f,
	input  wire  [`FPU_NUM_W-1:0]  acc_in,
	input  wire  [`FPU_MANT_W-1:0] sum,
	input  wire  [`FPU_EXP_W:0]    sum_exp,
	fpu_step_if.unit               stp,
	output logic [`FPU_NUM_W-1:0]  result,
	output logic                   zero,
	output logic                   ovf
);

	logic [`FPU_MANT_W-1:0]       n_m;
	// wide enough for 39 decrements below -128
	logic signed [`FPU_EXP_W+1:0] n_e;
	logic                         run;
	logic                         m_zero;
	logic                         m_norm;
	logic                         exp_hi;
	logic                         exp_lo;

	assign m_zero = (n_m == '0);
	assign m_norm = n_m[`FPU_MANT_W-1] ^ n_m[`FPU_MANT_W-2];
	assign exp_hi = (n_e > 10'sd127);
	assign exp_lo = (n_e < -10'sd128);

	// --------------------------------------------------
	// working mantissa and exponent
	// --------------------------------------------------

	always_ff @(posedge got_fp) begin
		if (stp.norm_go) begin
			if (stp.norm_acc) begin
				n_m <= acc_in[`FPU_NUM_W-1 -: `FPU_MANT_W];
				n_e <= {{2{acc_in[`FPU_EXP_W-1]}}, acc_in[`FPU_EXP_W-1:0]};
			end else begin
				n_m <= sum;
				n_e <= {sum_exp[`FPU_EXP_W], sum_exp};
			end
		end else if (run && !m_zero && !m_norm) begin
			n_m <= n_m << 1;
			n_e <= n_e - 1'b1;
		end
	end

	// result registered once, on the last step
	always_ff @(posedge got_fp or posedge _0_f) begin
		if (_0_f) begin
			run    <= 1'b0;
			result <= '0;
			zero   <= 1'b0;
			ovf    <= 1'b0;
		end else if (stp.norm_go) begin
			run <= 1'b1;
		end else if (run && (m_zero || m_norm)) begin
			run <= 1'b0;
			if (m_zero || exp_lo) begin
				result <= '0;
				zero   <= 1'b1;
				ovf    <= 1'b0;
			end else begin
				// too large keeps the low exponent byte
				result <= {n_m, n_e[`FPU_EXP_W-1:0]};
				zero   <= 1'b0;
				ovf    <= exp_hi;
			end
		end
	end

	assign stp.norm_done = ~run;

endmodule

`default_nettype wire

//--- source/fpu_top.sv
// top level of the FPU job unit, joins the sequencer and the datapath behind plain ports
`timescale 1ns/1ps
`default_nettype none
`include "fpu_defines.svh"

module fpu_top (
	input  wire                    got_fp,
	input  wire                    _0_f,
	input  wire                    efp,
	input  wire  [1:0]             op,
	input  wire  [`FPU_NUM_W-1:0]  acc_in,
	output wire                    read_fp,
	output wire  [1:0]             lp,
	input  wire  [`FPU_WORD_W-1:0] mem_word,
	input  wire                    mem_ok,
	output wire                    ekc_fp,
	output wire                    busy,
	output wire  [`FPU_NUM_W-1:0]  result,
	output wire                    zero,
	output wire                    ovf
);

	wire [`FPU_NUM_W-1:0]  operand;
	wire [`FPU_MANT_W-1:0] mant_a;
	wire [`FPU_MANT_W-1:0] mant_b;
	wire [`FPU_EXP_W-1:0]  exp_al;
	wire [`FPU_MANT_W-1:0] sum;
	wire [`FPU_EXP_W:0]    sum_exp;

	fpu_step_if stp ();

	// --------------------------------------------------
	// sequencer
	// --------------------------------------------------

	fpu_control u_control (
		.got_fp  (got_fp),
		._0_f    (_0_f),
		.efp     (efp),
		.op      (fpu_pkg::fp_op_e'(op)),
		.read_fp (read_fp),
		.lp      (lp),
		.mem_ok  (mem_ok),
		.ekc_fp  (ekc_fp),
		.busy    (busy),
		.stp     (stp.ctrl)
	);

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------

	operand_loader u_loader (
		.got_fp   (got_fp),
		._0_f     (_0_f),
		.mem_word (mem_word),
		.stp      (stp.unit),
		.operand  (operand)
	);

	exponent_align u_align (
		.got_fp  (got_fp),
		._0_f    (_0_f),
		.acc_in  (acc_in),
		.operand (operand),
		.stp     (stp.unit),
		.mant_a  (mant_a),
		.mant_b  (mant_b),
		.exp_out (exp_al)
	);

	mantissa_adder u_adder (
		.got_fp  (got_fp),
		._0_f    (_0_f),
		.mant_a  (mant_a),
		.mant_b  (mant_b),
		.exp_in  (exp_al),
		.stp     (stp.unit),
		.sum     (sum),
		.sum_exp (sum_exp)
	);

	normalizer u_norm (
		.got_fp  (got_fp),
		._0_f    (_0_f),
		.acc_in  (acc_in),
		.sum     (sum),
		.sum_exp (sum_exp),
		.stp     (stp.unit),
		.result  (result),
		.zero    (zero),
		.ovf     (ovf)
	);

endmodule

`default_nettype wire

//--- testbench/fpu_checker.sv
// concurrent assertions on the job sequencer strobes and states for binding into fpu_control
`timescale 1ns/1ps
`default_nettype none

module fpu_checker (
	input wire                     got_fp,
	input wire                     _0_f,
	input wire                     efp,
	input wire fpu_pkg::fp_state_e state,
	input wire                     read_fp,
	input wire [1:0]               lp,
	input wire                     ekc_fp,
	input wire                     busy
);

	// failed assertion count for the testbench top
	int unsigned fails = 0;

	// --------------------------------------------------
	// strobe and state rules
	// --------------------------------------------------

	ekc_single: assert property (@(posedge got_fp) disable iff (_0_f) ekc_fp |=> !ekc_fp)
	else begin
		$error("ekc_fp held for more than one cycle");
		fails++;
	end

	read_in_fetch: assert property (@(posedge got_fp) disable iff (_0_f)
		read_fp |-> (state == fpu_pkg::ST_FETCH))
	else begin
		$error("read_fp raised outside the fetch state");
		fails++;
	end

	lp_range: assert property (@(posedge got_fp) disable iff (_0_f) lp != 2'd3)
	else begin
		$error("word counter reached 3");
		fails++;
	end

	// an idle sequencer with no start strobe stays quiet
	idle_not_busy: assert property (@(posedge got_fp) disable iff (_0_f)
		((state == fpu_pkg::ST_IDLE) && !efp) |=> !busy)
	else begin
		$error("busy raised with no start strobe while idle");
		fails++;
	end

endmodule

`default_nettype wire

//--- testbench/fpu_monitor.sv
// reference model and scoreboard that watches the DUT ports and compares every finished job
`timescale 1ns/1ps
`default_nettype none
`include "fpu_defines.svh"

module fpu_monitor (
	input  wire                    got_fp,
	input  wire                    _0_f,
	input  wire                    efp,
	input  wire  [1:0]             op,
	input  wire  [`FPU_NUM_W-1:0]  acc_in,
	input  wire                    read_fp,
	input  wire  [1:0]             lp,
	input  wire  [`FPU_WORD_W-1:0] mem_word,
	input  wire                    mem_ok,
	input  wire                    ekc_fp,
	input  wire                    busy,
	input  wire  [`FPU_NUM_W-1:0]  result,
	input  wire                    zero,
	input  wire                    ovf,
	output int                     pass_cnt,
	output int                     fail_cnt,
	output int                     err_cnt
);

	logic [1:0]             jop;
	logic [`FPU_NUM_W-1:0]  jacc;
	logic [`FPU_WORD_W-1:0] jw [`FPU_WORDS];
	int                     nwords;
	int                     nreads;
	int                     job_no;
	bit                     pending;
	bit                     job_bad;

	initial begin
		pass_cnt = 0;
		fail_cnt = 0;
		err_cnt  = 0;
		job_no   = 0;
		pending  = 1'b0;
		job_bad  = 1'b0;
	end

	// --------------------------------------------------
	// reference model returning {zero, ovf, result}
	// --------------------------------------------------

	function automatic logic [49:0] expect_job(input logic [1:0] fop,
		input logic [`FPU_NUM_W-1:0] acc, input logic [`FPU_NUM_W-1:0] opd);
		logic signed [`FPU_MANT_W-1:0] ma;
		logic signed [`FPU_MANT_W-1:0] mb;
		logic signed [`FPU_EXP_W-1:0]  ea;
		logic signed [`FPU_EXP_W-1:0]  eb;
		logic [`FPU_MANT_W:0]          s;
		logic [`FPU_MANT_W-1:0]        m;
		int                            e;
		int                            diff;
		ma = acc[47:8];
		ea = acc[7:0];
		mb = opd[47:8];
		eb = opd[7:0];
		if (fop == fpu_pkg::OP_NRF) begin
			m = ma;
			e = ea;
		end else begin
			// smaller exponent side loses its low bits
			if (ea >= eb) begin
				diff = ea - eb;
				mb   = mb >>> diff;
				e    = ea;
			end else begin
				diff = eb - ea;
				ma   = ma >>> diff;
				e    = eb;
			end
			if (fop == fpu_pkg::OP_SD) begin
				s = {ma[39], ma} - {mb[39], mb};
			end else begin
				s = {ma[39], ma} + {mb[39], mb};
			end
			// sign lost so halve and bump the exponent
			if (s[40] != s[39]) begin
				m = s[40:1];
				e = e + 1;
			end else begin
				m = s[39:0];
			end
		end
		if (m == '0) begin
			return {2'b10, 48'h0};
		end
		while (m[39] == m[38]) begin
			m = m << 1;
			e = e - 1;
		end
		if (e < -128) begin
			return {2'b10, 48'h0};
		end
		return {1'b0, (e > 127), m, e[7:0]};
	endfunction

	task automatic finish_job();
		logic [49:0]           exp_v;
		logic [`FPU_NUM_W-1:0] exp_r;
		bit                    bad;
		exp_v = expect_job(jop, jacc, {jw[0], jw[1], jw[2]});
		exp_r = exp_v[47:0];
		bad   = job_bad;
		if (jop != fpu_pkg::OP_NRF && (nreads != 3 || nwords != 3)) begin
			$display("job %0d fetched %0d words with %0d read strobes, expected 3 of each",
				job_no, nwords, nreads);
			bad = 1'b1;
		end
		if (result !== exp_r) begin
			$display("Fail result expected %h got %h in job %0d", exp_r, result, job_no);
			bad = 1'b1;
		end
		if (zero !== exp_v[49]) begin
			$display("Fail zero expected %h got %h in job %0d", exp_v[49], zero, job_no);
			bad = 1'b1;
		end
		if (ovf !== exp_v[48]) begin
			$display("Fail ovf expected %h got %h in job %0d", exp_v[48], ovf, job_no);
			bad = 1'b1;
		end
		if (bad) begin
			fail_cnt++;
			$display("job %0d op %0d failed", job_no, jop);
		end else begin
			pass_cnt++;
			$display("job %0d op %0d ok, result %h zero %0d ovf %0d", job_no, jop, result,
				zero, ovf);
		end
		pending = 1'b0;
		job_no++;
	endtask

	// every port listed here reads all zeros out of reset
	task automatic check_reset_value(input string name, input logic [`FPU_NUM_W-1:0] got);
		if (got !== '0) begin
			$display("Fail %s expected %h got %h after reset", name, 48'h0, got);
			err_cnt++;
		end
	endtask

	// --------------------------------------------------
	// port watching
	// --------------------------------------------------

	always @(negedge _0_f) begin
		check_reset_value("read_fp", read_fp);
		check_reset_value("ekc_fp", ekc_fp);
		check_reset_value("busy", busy);
		check_reset_value("lp", lp);
		check_reset_value("result", result);
	end

	always @(posedge got_fp) begin
		if (!_0_f) begin
			if (busy !== pending) begin
				$display("Fail busy expected %h got %h", pending, busy);
				err_cnt++;
				job_bad = 1'b1;
			end
			if (read_fp) begin
				nreads++;
				if (!pending || jop == fpu_pkg::OP_NRF) begin
					$display("read strobe seen outside an add or subtract job");
					err_cnt++;
					job_bad = 1'b1;
				end
			end
			if (mem_ok && pending && jop != fpu_pkg::OP_NRF && nwords < 3) begin
				if (lp !== 2'(nwords)) begin
					$display("Fail lp expected %h got %h", 2'(nwords), lp);
					err_cnt++;
					job_bad = 1'b1;
				end
				jw[nwords] = mem_word;
				nwords++;
			end
			if (ekc_fp) begin
				if (!pending) begin
					$display("end strobe seen with no job running");
					err_cnt++;
				end else begin
					finish_job();
				end
			end else if (efp && !pending) begin
				// only a start seen while idle opens a job
				pending = 1'b1;
				job_bad = 1'b0;
				jop     = op;
				jacc    = acc_in;
				nwords  = 0;
				nreads  = 0;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_fpu.sv
// testbench top that runs random FPU jobs against the monitor's model
`timescale 1ns/1ps
`default_nettype none
`include "fpu_defines.svh"

module tb_fpu;

	localparam int JOBS        = 200;
	localparam int CLK_NS      = 10;
	localparam int WATCHDOG_NS = JOBS * 200 * CLK_NS;

	logic                   got_fp;
	logic                   _0_f;
	logic                   efp;
	logic [1:0]             op;
	logic [`FPU_NUM_W-1:0]  acc_in;
	wire                    read_fp;
	wire  [1:0]             lp;
	logic [`FPU_WORD_W-1:0] mem_word;
	logic                   mem_ok;
	wire                    ekc_fp;
	wire                    busy;
	wire  [`FPU_NUM_W-1:0]  result;
	wire                    zero;
	wire                    ovf;
	int                     pass_cnt;
	int                     fail_cnt;
	int                     err_cnt;
	integer                 seed;
	int                     delay;
	int                     pick;
	logic [`FPU_NUM_W-1:0]  opd;
	// operand words of the running job
	logic [`FPU_WORD_W-1:0] words [`FPU_WORDS];

	fpu_top dut0 (
		.got_fp   (got_fp),
		._0_f     (_0_f),
		.efp      (efp),
		.op       (op),
		.acc_in   (acc_in),
		.read_fp  (read_fp),
		.lp       (lp),
		.mem_word (mem_word),
		.mem_ok   (mem_ok),
		.ekc_fp   (ekc_fp),
		.busy     (busy),
		.result   (result),
		.zero     (zero),
		.ovf      (ovf)
	);

	fpu_monitor u_monitor (
		.got_fp   (got_fp),
		._0_f     (_0_f),
		.efp      (efp),
		.op       (op),
		.acc_in   (acc_in),
		.read_fp  (read_fp),
		.lp       (lp),
		.mem_word (mem_word),
		.mem_ok   (mem_ok),
		.ekc_fp   (ekc_fp),
		.busy     (busy),
		.result   (result),
		.zero     (zero),
		.ovf      (ovf),
		.pass_cnt (pass_cnt),
		.fail_cnt (fail_cnt),
		.err_cnt  (err_cnt)
	);

	bind fpu_control fpu_checker u_checker (
		.got_fp  (got_fp),
		._0_f    (_0_f),
		.efp     (efp),
		.state   (state),
		.read_fp (read_fp),
		.lp      (lp),
		.ekc_fp  (ekc_fp),
		.busy    (busy)
	);

	// normalized random number or, when loose, one shifted right for the nrf job
	function automatic logic [`FPU_NUM_W-1:0] rand_number(input bit loose);
		logic [63:0]                   r;
		logic signed [`FPU_MANT_W-1:0] m;
		logic [`FPU_EXP_W-1:0]         e;
		int                            kind;
		r     = {$random(seed), $random(seed)};
		m     = r[39:0];
		m[38] = ~m[39];
		e     = 8'($random(seed) % 21);
		kind  = {$random(seed)} % 8;
		case (kind)
			0: m = '0;
			1: e = 8'h7f;
			2: e = 8'h80;
			3: e = 8'($random(seed));
			default: e = e;
		endcase
		if (loose) begin
			m = m >>> ({$random(seed)} % 20);
		end
		return {m, e};
	endfunction

	initial begin
		got_fp = 1'b0;
		forever #(CLK_NS / 2) got_fp = ~got_fp;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("run timed out after %0d ns with %0d jobs finished", WATCHDOG_NS,
			pass_cnt + fail_cnt);
		$display("TEST FAIL");
		$finish;
	end

	// --------------------------------------------------
	// memory responder with 1 to 4 cycles per read
	// --------------------------------------------------

	initial begin
		forever begin
			@(posedge got_fp);
			if (read_fp && !_0_f) begin
				delay = 1 + {$random(seed)} % 4;
				repeat (delay - 1) @(posedge got_fp);
				@(negedge got_fp);
				mem_word = words[lp];
				mem_ok   = 1'b1;
				@(negedge got_fp);
				mem_ok   = 1'b0;
			end
		end
	end

	// --------------------------------------------------
	// job stimulus
	// --------------------------------------------------

	initial begin
		seed     = 84;
		_0_f     = 1'b1;
		efp      = 1'b0;
		op       = 2'd0;
		acc_in   = '0;
		mem_word = '0;
		mem_ok   = 1'b0;
		for (int i = 0; i < `FPU_WORDS; i++) begin
			words[i] = '0;
		end
		repeat (8) @(posedge got_fp);
		@(negedge got_fp);
		_0_f = 1'b0;
		for (int j = 0; j < JOBS; j++) begin
			@(negedge got_fp);
			op     = 2'({$random(seed)} % 3);
			acc_in = rand_number(op == fpu_pkg::OP_NRF);
			opd    = rand_number(1'b0);
			pick   = {$random(seed)} % 8;
			if (pick == 0) begin
				// doubling at the top exponent overflows
				op          = fpu_pkg::OP_AD;
				acc_in[7:0] = 8'h7f;
				opd         = acc_in;
			end else if (pick == 1) begin
				// exact cancellation
				op  = fpu_pkg::OP_SD;
				opd = acc_in;
			end
			words[0] = opd[47:32];
			words[1] = opd[31:16];
			words[2] = opd[15:0];
			efp      = 1'b1;
			@(negedge got_fp);
			efp = 1'b0;
			if ({$random(seed)} % 4 == 0) begin
				// start strobe while busy
				@(negedge got_fp);
				op     = 2'({$random(seed)} % 3);
				acc_in = rand_number(1'b1);
				efp    = 1'b1;
				@(negedge got_fp);
				efp    = 1'b0;
			end
			do begin
				@(posedge got_fp);
			end while (!ekc_fp);
		end
		repeat (2) @(negedge got_fp);
		$display("jobs passed %0d, failed %0d, protocol errors %0d, assertion failures %0d",
			pass_cnt, fail_cnt, err_cnt, dut0.u_control.u_checker.fails);
		if (fail_cnt == 0 && err_cnt == 0 && pass_cnt == JOBS
			&& dut0.u_control.u_checker.fails == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/fpu_pkg.sv
source/fpu_step_if.sv
source/fpu_control.sv
source/operand_loader.sv
source/exponent_align.sv
source/mantissa_adder.sv
source/normalizer.sv
source/fpu_top.sv
testbench/fpu_checker.sv
testbench/fpu_monitor.sv
testbench/tb_fpu.sv

//--- Bender.yml
package:
  name: fpu_job_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fpu_pkg.sv
      - source/fpu_step_if.sv
      - source/fpu_control.sv
      - source/operand_loader.sv
      - source/exponent_align.sv
      - source/mantissa_adder.sv
      - source/normalizer.sv
      - source/fpu_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - testbench/fpu_checker.sv
      - testbench/fpu_monitor.sv
      - testbench/tb_fpu.sv
